// File: src.f
+incdir+design
design/rob_pkg.sv
design/exec_pkg.sv
design/issue_dispatch.sv
design/exec_lane.sv
design/writeback_arbiter.sv
design/reorder_buffer.sv
design/ooo_core_top.sv
test/rob_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal -f src.f --top-module rob_tb -Mdir "$OBJ" -o rob_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/rob_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "run passed"
    exit 0
fi

echo "pass message not found in $LOG"
exit 1

// File: test/rob_cases.txt
# columns: op rd a b pred pc target, one instruction per line
# rd and pred in decimal, a b pc target in hex
MUL 1  00001234 00000100 0 00001000 00000000
ADD 2  00000005 00000007 0 00001004 00000000
SUB 3  00000005 00000007 0 00001008 00000000
XOR 4  a5a5a5a5 ffff0000 0 0000100c 00000000
AND 5  a5a5a5a5 0f0f0f0f 0 00001010 00000000
SLT 6  fffffff0 00000003 0 00001014 00000000
SLT 7  00000003 fffffff0 0 00001018 00000000
ST  0  00002000 00000010 0 0000101c 00000000
BEQ 0  00000009 00000009 1 00001020 00003000
ADD 8  7fffffff 00000001 0 00003000 00000000
BEQ 0  00000001 00000002 0 00003004 00003100
MUL 9  ffffffff ffffffff 0 00003008 00000000
BEQ 0  00000004 00000004 0 0000300c 00004000
ADD 31 0000dead 0000beef 0 00003010 00000000
MUL 10 00000003 00000005 0 00004000 00000000
MUL 11 00000007 00000009 0 00004004 00000000
MUL 12 0000ffff 00010001 0 00004008 00000000
MUL 13 12345678 00000010 0 0000400c 00000000
MUL 14 80000000 00000002 0 00004010 00000000
ST  0  00000100 fffffff0 0 00004014 00000000
BEQ 0  00000001 00000002 1 00004018 00005000
SUB 30 00000001 00000001 0 0000401c 00000000
ADD 15 00000010 00000020 0 0000401c 00000000
SUB 16 00000000 00000001 0 00004020 00000000
XOR 17 ffffffff 12345678 0 00004024 00000000
AND 18 ffffffff 00ff00ff 0 00004028 00000000
ST  0  00000004 00000004 0 0000402c 00000000

// File: test/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;

    typedef struct packed {
        logic [15:0]     idx;
        exec_pkg::op_t   op;
        rob_pkg::regnm_t rd;
        rob_pkg::data_t  a;
        rob_pkg::data_t  b;
        logic            pred;
        rob_pkg::addr_t  pc;
        rob_pkg::addr_t  target;
        rob_pkg::tag_t   tag;
    } inst_t;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            in_valid;
    exec_pkg::op_t   in_op;
    rob_pkg::regnm_t in_rd;
    rob_pkg::data_t  in_a;
    rob_pkg::data_t  in_b;
    logic            in_pred_taken;
    rob_pkg::addr_t  in_pc;
    rob_pkg::addr_t  in_target;
    logic            in_ready;
    logic            commit_valid;
    rob_pkg::regnm_t commit_rd;
    rob_pkg::data_t  commit_data;
    rob_pkg::tag_t   commit_tag;
    logic            store_valid;
    rob_pkg::data_t  store_data;
    logic            flush;
    rob_pkg::addr_t  redirect_pc;

    inst_t         case_q[$];
    inst_t         ref_q[$];
    int            next_case = 0;
    int            gap = 0;
    bit            saw_stall = 1'b0;
    bit            cases_loaded = 1'b0;
    bit            took = 1'b0;
    bit            done = 1'b0;
    rob_pkg::tag_t tag_ctr = '0;

    ooo_core_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_rd        (in_rd),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_pred_taken(in_pred_taken),
        .in_pc        (in_pc),
        .in_target    (in_target),
        .in_ready     (in_ready),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_tag   (commit_tag),
        .store_valid  (store_valid),
        .store_data   (store_data),
        .flush        (flush),
        .redirect_pc  (redirect_pc)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp,
                            input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0d ns: %s, got %0h expected %0h",
                                $time, what, got, exp));
        end
    endtask

    function automatic bit is_mispredict(inst_t e);
        return (e.op == exec_pkg::BEQ) && ((e.a == e.b) != e.pred);
    endfunction

    // expected result from the opcode rules
    function automatic rob_pkg::data_t expected_result(inst_t e);
        rob_pkg::data_t res;
        case (e.op)
            exec_pkg::ADD: res = e.a + e.b;
            exec_pkg::SUB: res = e.a - e.b;
            exec_pkg::XOR: res = e.a ^ e.b;
            exec_pkg::AND: res = e.a & e.b;
            exec_pkg::SLT: res = ($signed(e.a) < $signed(e.b)) ? 1 : 0;
            exec_pkg::MUL: res = e.a * e.b;
            default:       res = e.a + e.b;
        endcase
        return res;
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        int          rd;
        int          pred;
        string       line;
        logic [63:0] op_name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] target;
        inst_t       c;
        fd = $fopen("test/rob_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open test/rob_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %h %h %d %h %h", op_name, rd, a, b, pred, pc, target);
            if (n == 7) begin
                c = '0;
                c.idx = 16'(case_q.size());
                case (op_name)
                    "ADD":   c.op = exec_pkg::ADD;
                    "SUB":   c.op = exec_pkg::SUB;
                    "XOR":   c.op = exec_pkg::XOR;
                    "AND":   c.op = exec_pkg::AND;
                    "SLT":   c.op = exec_pkg::SLT;
                    "MUL":   c.op = exec_pkg::MUL;
                    "BEQ":   c.op = exec_pkg::BEQ;
                    "ST":    c.op = exec_pkg::ST;
                    default: abort_run($sformatf("unknown opcode %0s in case file", op_name));
                endcase
                c.rd     = rob_pkg::regnm_t'(rd);
                c.a      = a;
                c.b      = b;
                c.pred   = pred[0];
                c.pc     = pc;
                c.target = target;
                case_q.push_back(c);
            end else if (n > 0) begin
                abort_run("malformed line in case file");
            end
        end
        $fclose(fd);
    endtask

    task automatic accept_current();
        inst_t c;
        c = case_q[next_case];
        c.tag = tag_ctr;
        ref_q.push_back(c);
        tag_ctr = tag_ctr + 1'b1;
        next_case++;
        if ($urandom % 4 == 0) begin
            gap = int'($urandom % 3) + 1;
        end else begin
            gap = 0;
        end
    endtask

    task automatic drive_next();
        inst_t c;
        if (gap > 0 || next_case >= case_q.size()) begin
            in_valid <= 1'b0;
            if (gap > 0) begin
                gap--;
            end
        end else begin
            c = case_q[next_case];
            in_valid      <= 1'b1;
            in_op         <= c.op;
            in_rd         <= c.rd;
            in_a          <= c.a;
            in_b          <= c.b;
            in_pred_taken <= c.pred;
            in_pc         <= c.pc;
            in_target     <= c.target;
        end
    endtask

    task automatic observe_outputs();
        inst_t          e;
        bit             exp_store;
        bit             exp_flush;
        rob_pkg::addr_t exp_redirect;
        if (!commit_valid && !store_valid) begin
            check_eq(flush, 0, "flush without a commit");
        end else if (ref_q.size() == 0) begin
            abort_run("a commit appeared with no instruction outstanding");
        end else begin
            e = ref_q.pop_front();
            exp_store = (e.op == exec_pkg::ST);
            exp_flush = is_mispredict(e);
            check_eq(store_valid, exp_store, "store_valid");
            check_eq(commit_valid, !exp_store, "commit_valid");
            check_eq(commit_tag, e.tag, "commit_tag");
            check_eq(flush, exp_flush, "flush");
            if (exp_store) begin
                check_eq(store_data, rob_pkg::data_t'(e.a + e.b), "store_data");
            end else if (e.op == exec_pkg::BEQ) begin
                check_eq(commit_rd, 0, "branch commit_rd");
            end else begin
                check_eq(commit_rd, e.rd, "commit_rd");
                check_eq(commit_data, expected_result(e), "commit_data");
            end
            if (exp_flush) begin
                exp_redirect = (e.a == e.b) ? e.target : rob_pkg::addr_t'(e.pc + 4);
                check_eq(redirect_pc, exp_redirect, "redirect_pc");
                // drop younger work and skip the wrong path line
                ref_q.delete();
                next_case = int'(e.idx) + 2;
                tag_ctr = '0;
                gap = 0;
            end
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_op         = exec_pkg::ADD;
        in_rd         = '0;
        in_a          = '0;
        in_b          = '0;
        in_pred_taken = 1'b0;
        in_pc         = '0;
        in_target     = '0;
        void'($urandom(86083));
        load_cases();
        cases_loaded = 1'b1;

        repeat (4) begin
            @(negedge clk);
            check_eq(in_ready, 0, "in_ready during reset");
            check_eq(commit_valid, 0, "commit_valid during reset");
            check_eq(store_valid, 0, "store_valid during reset");
            check_eq(flush, 0, "flush during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_eq(commit_valid, 0, "commit_valid after reset");
        check_eq(store_valid, 0, "store_valid after reset");
        check_eq(flush, 0, "flush after reset");

        while (!done) begin
            @(posedge clk);
            if (took) begin
                accept_current();
            end
            drive_next();
            @(negedge clk);
            observe_outputs();
            took = in_valid && in_ready;
            if (in_valid && !in_ready) begin
                saw_stall = 1'b1;
            end
            done = (next_case >= case_q.size()) && (ref_q.size() == 0);
        end

        // nothing may retire once the model is drained
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (20) begin
            @(negedge clk);
            check_eq(commit_valid, 0, "commit_valid after drain");
            check_eq(store_valid, 0, "store_valid after drain");
            check_eq(flush, 0, "flush after drain");
        end

        check_eq(saw_stall, 1, "in_ready never dropped under load");
        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        wait (cases_loaded);
        repeat (200 * case_q.size() + 100) @(posedge clk);
        abort_run("timeout: the run did not finish within its cycle limit");
    end

endmodule

// File: design/ooo_core_top.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module ooo_core_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  exec_pkg::op_t    in_op,
    input  rob_pkg::regnm_t  in_rd,
    input  rob_pkg::data_t   in_a,
    input  rob_pkg::data_t   in_b,
    input  logic             in_pred_taken,
    input  rob_pkg::addr_t   in_pc,
    input  rob_pkg::addr_t   in_target,
    output logic             in_ready,
    output logic             commit_valid,
    output rob_pkg::regnm_t  commit_rd,
    output rob_pkg::data_t   commit_data,
    output rob_pkg::tag_t    commit_tag,
    output logic             store_valid,
    output rob_pkg::data_t   store_data,
    output logic             flush,
    output rob_pkg::addr_t   redirect_pc
);
    logic                  alloc_en;
    rob_pkg::regnm_t       alloc_rd;
    rob_pkg::entry_kind_t  alloc_kind;
    rob_pkg::tag_t         alloc_tag;
    logic                  rob_full;

    logic [`NUM_LANES-1:0] lane_idle;
    logic [`NUM_LANES-1:0] lane_start;
    exec_pkg::op_t         lane_op;
    rob_pkg::data_t        lane_a;
    rob_pkg::data_t        lane_b;
    rob_pkg::tag_t         lane_tag;
    rob_pkg::addr_t        lane_target;

    logic [`NUM_LANES-1:0] res_valid;
    logic [`NUM_LANES-1:0] res_grant;
    logic [`NUM_LANES-1:0] res_taken;
    rob_pkg::tag_t         res_tag    [`NUM_LANES];
    rob_pkg::data_t        res_data   [`NUM_LANES];
    rob_pkg::addr_t        res_target [`NUM_LANES];

    logic                  wb_en;
    rob_pkg::tag_t         wb_tag;
    rob_pkg::data_t        wb_data;
    logic                  wb_taken;
    rob_pkg::addr_t        wb_target;

    issue_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_rd      (in_rd),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_target  (in_target),
        .rob_full   (rob_full),
        .alloc_tag  (alloc_tag),
        .lane_idle  (lane_idle),
        .flush      (flush),
        .in_ready   (in_ready),
        .alloc_en   (alloc_en),
        .alloc_rd   (alloc_rd),
        .alloc_kind (alloc_kind),
        .lane_start (lane_start),
        .lane_op    (lane_op),
        .lane_a     (lane_a),
        .lane_b     (lane_b),
        .lane_tag   (lane_tag),
        .lane_target(lane_target)
    );

    for (genvar k = 0; k < `NUM_LANES; k++) begin : g_lane
        exec_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .start     (lane_start[k]),
            .op        (lane_op),
            .a         (lane_a),
            .b         (lane_b),
            .tag       (lane_tag),
            .target    (lane_target),
            .grant     (res_grant[k]),
            .flush     (flush),
            .idle      (lane_idle[k]),
            .res_valid (res_valid[k]),
            .res_tag   (res_tag[k]),
            .res_data  (res_data[k]),
            .res_taken (res_taken[k]),
            .res_target(res_target[k])
        );
    end

    writeback_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_data  (res_data),
        .res_taken (res_taken),
        .res_target(res_target),
        .res_grant (res_grant),
        .wb_en     (wb_en),
        .wb_tag    (wb_tag),
        .wb_data   (wb_data),
        .wb_taken  (wb_taken),
        .wb_target (wb_target)
    );

    // prediction and pc bypass the dispatcher
    reorder_buffer u_rob (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_en    (alloc_en),
        .alloc_rd    (alloc_rd),
        .alloc_kind  (alloc_kind),
        .alloc_pred  (in_pred_taken),
        .alloc_pc    (in_pc),
        .wb_en       (wb_en),
        .wb_tag      (wb_tag),
        .wb_data     (wb_data),
        .wb_taken    (wb_taken),
        .wb_target   (wb_target),
        .alloc_tag   (alloc_tag),
        .rob_full    (rob_full),
        .commit_valid(commit_valid),
        .commit_rd   (commit_rd),
        .commit_data (commit_data),
        .commit_tag  (commit_tag),
        .store_valid (store_valid),
        .store_data  (store_data),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

// File: design/reorder_buffer.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module reorder_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  alloc_en,
    input  rob_pkg::regnm_t       alloc_rd,
    input  rob_pkg::entry_kind_t  alloc_kind,
    input  logic                  alloc_pred,
    input  rob_pkg::addr_t        alloc_pc,
    input  logic                  wb_en,
    input  rob_pkg::tag_t         wb_tag,
    input  rob_pkg::data_t        wb_data,
    input  logic                  wb_taken,
    input  rob_pkg::addr_t        wb_target,
    output rob_pkg::tag_t         alloc_tag,
    output logic                  rob_full,
    output logic                  commit_valid,
    output rob_pkg::regnm_t       commit_rd,
    output rob_pkg::data_t        commit_data,
    output rob_pkg::tag_t         commit_tag,
    output logic                  store_valid,
    output rob_pkg::data_t        store_data,
    output logic                  flush,
    output rob_pkg::addr_t        redirect_pc
);
    localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

    // per-entry payload
    rob_pkg::entry_kind_t kind_q   [`ROB_DEPTH];
    rob_pkg::regnm_t      rd_q     [`ROB_DEPTH];
    rob_pkg::data_t       data_q   [`ROB_DEPTH];
    logic                 pred_q   [`ROB_DEPTH];
    logic                 actual_q [`ROB_DEPTH];
    rob_pkg::addr_t       pc_q     [`ROB_DEPTH];
    rob_pkg::addr_t       target_q [`ROB_DEPTH];

    logic [`ROB_DEPTH-1:0] done_q;
    rob_pkg::tag_t         head;
    rob_pkg::tag_t         tail;
    logic [CNT_W-1:0]      count;
    logic                  head_ready;
    logic                  head_mispred;

    function automatic rob_pkg::tag_t next_ptr(rob_pkg::tag_t p);
        return (p == rob_pkg::tag_t'(`ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign alloc_tag = tail;
    assign rob_full  = (count == CNT_W'(`ROB_DEPTH));

    // nothing commits behind a flushing branch
    assign head_ready   = (count != '0) && done_q[head] && !flush;
    assign head_mispred = (kind_q[head] == rob_pkg::KIND_BRANCH) &&
                          (pred_q[head] != actual_q[head]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done_q       <= '0;
            commit_valid <= 1'b0;
            store_valid  <= 1'b0;
            flush        <= 1'b0;
        end else begin
            commit_valid <= 1'b0;
            store_valid  <= 1'b0;
            flush        <= 1'b0;
            if (flush) begin
                // drop every younger entry
                head   <= '0;
                tail   <= '0;
                count  <= '0;
                done_q <= '0;
            end else begin
                if (alloc_en) begin
                    tail         <= next_ptr(tail);
                    done_q[tail] <= 1'b0;
                end
                if (wb_en) begin
                    done_q[wb_tag] <= 1'b1;
                end
                if (head_ready) begin
                    head <= next_ptr(head);
                    if (kind_q[head] == rob_pkg::KIND_STORE) begin
                        store_valid <= 1'b1;
                    end else begin
                        commit_valid <= 1'b1;
                    end
                    flush <= head_mispred;
                end
                count <= count + CNT_W'(alloc_en) - CNT_W'(head_ready);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            kind_q[tail] <= alloc_kind;
            rd_q[tail]   <= alloc_rd;
            pred_q[tail] <= alloc_pred;
            pc_q[tail]   <= alloc_pc;
        end
        if (wb_en) begin
            data_q[wb_tag]   <= wb_data;
            actual_q[wb_tag] <= wb_taken;
            target_q[wb_tag] <= wb_target;
        end
        if (head_ready) begin
            // branches write no register
            commit_rd   <= (kind_q[head] == rob_pkg::KIND_BRANCH) ? '0 : rd_q[head];
            commit_data <= data_q[head];
            commit_tag  <= head;
            store_data  <= data_q[head];
            redirect_pc <= actual_q[head] ? target_q[head] : pc_q[head] + `ADDR_W'(4);
        end
    end

endmodule

// File: design/writeback_arbiter.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module writeback_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`NUM_LANES-1:0]  res_valid,
    input  rob_pkg::tag_t          res_tag    [`NUM_LANES],
    input  rob_pkg::data_t         res_data   [`NUM_LANES],
    input  logic [`NUM_LANES-1:0]  res_taken,
    input  rob_pkg::addr_t         res_target [`NUM_LANES],
    output logic [`NUM_LANES-1:0]  res_grant,
    output logic                   wb_en,
    output rob_pkg::tag_t          wb_tag,
    output rob_pkg::data_t         wb_data,
    output logic                   wb_taken,
    output rob_pkg::addr_t         wb_target
);
    localparam int PTR_W = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;

    logic [PTR_W-1:0] rr_ptr;
    logic [PTR_W-1:0] sel;
    logic             found;

    // scan starting at the lane after the last winner
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            idx = int'(rr_ptr) + i;
            if (idx >= `NUM_LANES) begin
                idx = idx - `NUM_LANES;
            end
            if (!found && res_valid[idx]) begin
                found = 1'b1;
                sel   = PTR_W'(idx);
            end
        end
    end

    always_comb begin
        res_grant = '0;
        if (found) begin
            res_grant[sel] = 1'b1;
        end
    end

    assign wb_en     = found;
    assign wb_tag    = res_tag[sel];
    assign wb_data   = res_data[sel];
    assign wb_taken  = res_taken[sel];
    assign wb_target = res_target[sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (found) begin
            rr_ptr <= (sel == PTR_W'(`NUM_LANES - 1)) ? '0 : sel + 1'b1;
        end
    end

endmodule

// File: design/exec_lane.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module exec_lane (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  exec_pkg::op_t   op,
    input  rob_pkg::data_t  a,
    input  rob_pkg::data_t  b,
    input  rob_pkg::tag_t   tag,
    input  rob_pkg::addr_t  target,
    input  logic            grant,
    input  logic            flush,
    output logic            idle,
    output logic            res_valid,
    output rob_pkg::tag_t   res_tag,
    output rob_pkg::data_t  res_data,
    output logic            res_taken,
    output rob_pkg::addr_t  res_target
);
    localparam int LAT_W = $clog2(`MUL_CYCLES + 1);

    logic             busy;
    logic [LAT_W-1:0] cnt;
    rob_pkg::data_t   result;

    always_comb begin
        case (op)
            exec_pkg::ADD: result = a + b;
            exec_pkg::SUB: result = a - b;
            exec_pkg::XOR: result = a ^ b;
            exec_pkg::AND: result = a & b;
            exec_pkg::SLT: result = rob_pkg::data_t'($signed(a) < $signed(b));
            exec_pkg::MUL: result = a * b;
            exec_pkg::ST:  result = a + b;
            default:       result = '0;
        endcase
    end

    assign idle      = !busy;
    assign res_valid = busy && (cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (flush) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start && !busy) begin
            busy <= 1'b1;
            cnt  <= LAT_W'(exec_pkg::op_latency(op) - 1);
        end else if (busy && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else if (res_valid && grant) begin
            busy <= 1'b0;
        end
    end

    // result is ready at start, the counter only paces its release
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            res_tag    <= tag;
            res_data   <= result;
            res_taken  <= (op == exec_pkg::BEQ) && (a == b);
            res_target <= target;
        end
    end

endmodule

// File: design/issue_dispatch.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module issue_dispatch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  exec_pkg::op_t           in_op,
    input  rob_pkg::regnm_t         in_rd,
    input  rob_pkg::data_t          in_a,
    input  rob_pkg::data_t          in_b,
    input  rob_pkg::addr_t          in_target,
    input  logic                    rob_full,
    input  rob_pkg::tag_t           alloc_tag,
    input  logic [`NUM_LANES-1:0]   lane_idle,
    input  logic                    flush,
    output logic                    in_ready,
    output logic                    alloc_en,
    output rob_pkg::regnm_t         alloc_rd,
    output rob_pkg::entry_kind_t    alloc_kind,
    output logic [`NUM_LANES-1:0]   lane_start,
    output exec_pkg::op_t           lane_op,
    output rob_pkg::data_t          lane_a,
    output rob_pkg::data_t          lane_b,
    output rob_pkg::tag_t           lane_tag,
    output rob_pkg::addr_t          lane_target
);
    localparam int IDLE_W = $clog2(`NUM_LANES + 1);

    logic                  started;
    logic                  stg_valid;
    logic                  accept;
    logic                  issue;
    logic [IDLE_W-1:0]     idle_cnt;
    logic [`NUM_LANES-1:0] first_idle;

    // lowest idle lane wins, plus a count of idle lanes
    always_comb begin
        first_idle = '0;
        idle_cnt   = '0;
        for (int k = 0; k < `NUM_LANES; k++) begin
            if (lane_idle[k] && first_idle == '0) begin
                first_idle[k] = 1'b1;
            end
            idle_cnt = idle_cnt + IDLE_W'(lane_idle[k]);
        end
    end

    // the held instruction already claims one idle lane
    assign in_ready   = started && !rob_full && !flush && (idle_cnt > IDLE_W'(stg_valid));
    assign accept     = in_valid && in_ready;
    assign issue      = stg_valid && (|lane_idle) && !flush;
    assign lane_start = issue ? first_idle : '0;

    assign alloc_en   = accept;
    assign alloc_rd   = in_rd;
    assign alloc_kind = exec_pkg::op_kind(in_op);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started   <= 1'b0;
            stg_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (flush) begin
                stg_valid <= 1'b0;
            end else if (accept) begin
                stg_valid <= 1'b1;
            end else if (issue) begin
                stg_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lane_op     <= in_op;
            lane_a      <= in_a;
            lane_b      <= in_b;
            lane_tag    <= alloc_tag;
            lane_target <= in_target;
        end
    end

endmodule

// File: design/exec_pkg.sv
`include "rob_config.svh"

package exec_pkg;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        XOR = 3'd2,
        AND = 3'd3,
        SLT = 3'd4,
        MUL = 3'd5,
        BEQ = 3'd6,
        ST  = 3'd7
    } op_t;

    // kind handed to the reorder buffer at allocation
    function automatic rob_pkg::entry_kind_t op_kind(op_t op);
        case (op)
            BEQ:     return rob_pkg::KIND_BRANCH;
            ST:      return rob_pkg::KIND_STORE;
            default: return rob_pkg::KIND_REG;
        endcase
    endfunction

    // cycles from lane start to result valid
    function automatic int unsigned op_latency(op_t op);
        case (op)
            SLT:     return 2;
            MUL:     return `MUL_CYCLES;
            default: return 1;
        endcase
    endfunction

endpackage

// File: design/rob_pkg.sv
`include "rob_config.svh"

package rob_pkg;

    // reorder buffer index
    typedef logic [$clog2(`ROB_DEPTH)-1:0] tag_t;

    typedef logic [`REG_W-1:0]  regnm_t;
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`ADDR_W-1:0] addr_t;

    // what happens to an entry at commit
    typedef enum logic [1:0] {
        KIND_REG    = 2'd0,
        KIND_STORE  = 2'd1,
        KIND_BRANCH = 2'd2
    } entry_kind_t;

endpackage

// File: design/rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// reorder buffer entries
`define ROB_DEPTH 16

// identical execution lanes
`define NUM_LANES 3

`define DATA_W 32
`define ADDR_W 32

// architectural register name
`define REG_W 5

// mul latency in cycles
`define MUL_CYCLES 4

`endif
